/* lsq_config.svh */
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// ============================================================
// Queue geometry
// ============================================================

// Number of queue entries
// Any power of two from 4 to 32 works since the tail simply wraps
`define LSQ_ENTRIES 8

// Width of an entry index, derived from the depth
`define LSQ_IW ($clog2(`LSQ_ENTRIES))

// ============================================================
// Data path widths
// ============================================================

// Virtual and physical address width
`define LSQ_AW 32
// Result value width
`define LSQ_DW 32
// Result flags width, carried on the command but not stored in an entry
`define LSQ_FW 8
// Program-order sequence number width
`define LSQ_SW 8

`endif

/* lsq_cmd_pkg.sv */
`default_nettype none

`include "lsq_config.svh"

package lsq_cmd_pkg;

	// ============================================================
	// Command opcodes
	// ============================================================

	// One command per cycle, each aimed at a single entry
	// ENQ is the exception and always lands at the tail
	typedef enum logic [2:0] {
		OP_NOP    = 3'd0,
		OP_ENQ    = 3'd1,
		OP_SETADR = 3'd2,
		OP_INCADR = 3'd3,
		OP_SETRES = 3'd4,
		OP_INV    = 3'd5
	} lsq_op_e;

	// ============================================================
	// Command payload
	// ============================================================

	// Address view used by ENQ (virtual address) and SETADR (physical address)
	// The spare field pads the view out to the width of the result view
	typedef struct packed {
		logic [1:0]                             memsz;
		logic                                   load;
		logic                                   store;
		logic [`LSQ_FW+`LSQ_DW-`LSQ_AW-5:0]    spare;
		logic [`LSQ_AW-1:0]                     adr;
	} lsq_adr_view_t;

	// Result view used by SETRES and INV
	typedef struct packed {
		logic [`LSQ_FW-1:0] flags;
		logic [`LSQ_DW-1:0] value;
	} lsq_res_view_t;

	// The same payload word is read either way depending on the opcode
	typedef union packed {
		lsq_adr_view_t adr;
		lsq_res_view_t res;
	} lsq_payload_u;

endpackage

`default_nettype wire

/* lsq_entry_pkg.sv */
`default_nettype none

`include "lsq_config.svh"

package lsq_entry_pkg;

	// ============================================================
	// Entry state
	// ============================================================

	// IDLE is a fresh entry
	// LINE_STEP marks an access that has moved on to its next 64-byte line
	// FORWARDED marks a load whose result came from a committing store
	typedef enum logic [1:0] {
		IDLE      = 2'b00,
		LINE_STEP = 2'b01,
		FORWARDED = 2'b11
	} lsq_state_e;

	// ============================================================
	// Access size
	// ============================================================

	// Byte, 16-bit wyde, 32-bit tetra and 64-bit octa
	// Loads must match the store size exactly to receive a forward
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} lsq_memsz_e;

	// ============================================================
	// Program order
	// ============================================================

	// A larger number is younger
	// No wrap handling so a run stays below 2**LSQ_SW enqueues
	typedef logic [`LSQ_SW-1:0] lsq_seq_t;

endpackage

`default_nettype wire

/* lsq_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module lsq_cmd_decode
	import lsq_cmd_pkg::*;
	import lsq_entry_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cmd_valid,
	input  lsq_op_e                 cmd_op,
	input  logic [`LSQ_IW-1:0]      cmd_idx,
	input  lsq_payload_u            cmd_payload,
	input  logic                    cmd_commit,
	output logic [`LSQ_ENTRIES-1:0] enq_sel,
	output logic [`LSQ_ENTRIES-1:0] adr_sel,
	output logic [`LSQ_ENTRIES-1:0] inc_sel,
	output logic [`LSQ_ENTRIES-1:0] res_sel,
	output logic [`LSQ_ENTRIES-1:0] inv_sel,
	output lsq_payload_u            bc_payload,
	output logic                    bc_commit,
	output lsq_seq_t                bc_seq,
	output logic                    commit_scan,
	output logic [`LSQ_IW-1:0]      tail
);

	// Count of enqueues so far
	// The next operation is numbered one past it so the first gets 1
	lsq_seq_t seq_cnt;

	// One-hot forms of the command index and the tail
	logic [`LSQ_ENTRIES-1:0] idx_hot;
	logic [`LSQ_ENTRIES-1:0] tail_hot;

	logic is_enq;

	// ============================================================
	// Command decode
	// ============================================================

	assign is_enq = cmd_valid && (cmd_op == OP_ENQ);

	always_comb begin
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			idx_hot[i] = (cmd_idx == i[`LSQ_IW-1:0]);
			tail_hot[i] = (tail == i[`LSQ_IW-1:0]);
		end
	end

	// ENQ ignores the index and takes the slot at the tail
	assign enq_sel = is_enq ? tail_hot : '0;
	assign adr_sel = (cmd_valid && cmd_op == OP_SETADR) ? idx_hot : '0;
	assign inc_sel = (cmd_valid && cmd_op == OP_INCADR) ? idx_hot : '0;
	assign res_sel = (cmd_valid && cmd_op == OP_SETRES) ? idx_hot : '0;
	assign inv_sel = (cmd_valid && cmd_op == OP_INV) ? idx_hot : '0;

	// Payload and commit go to every entry and only the selected one acts
	assign bc_payload = cmd_payload;
	assign bc_commit = cmd_commit;
	assign bc_seq = seq_cnt + 1'b1;

	// A committing invalidation triggers the store-to-load forward scan
	assign commit_scan = cmd_valid && (cmd_op == OP_INV) && cmd_commit;

	// ============================================================
	// Allocation tail and sequence counter
	// ============================================================

	// The issuer keeps at most LSQ_ENTRIES operations in flight, so the tail never overruns
	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
			seq_cnt <= '0;
		end else if (is_enq) begin
			// Power-of-two depth lets the tail wrap on its own
			tail <= tail + 1'b1;
			seq_cnt <= seq_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* lsq_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module lsq_entry
	import lsq_cmd_pkg::*;
	import lsq_entry_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               enq,
	input  logic               set_adr,
	input  logic               inc_adr,
	input  logic               set_res,
	input  logic               inv,
	input  lsq_payload_u       payload,
	input  logic               commit,
	input  lsq_seq_t           seq,
	input  logic               fwd_hit,
	input  logic [`LSQ_DW-1:0] fwd_data,
	output logic               valid,
	output logic               load,
	output logic               store,
	output logic               agen,
	output lsq_memsz_e         memsz,
	output logic [`LSQ_AW-1:0] vadr,
	output logic [`LSQ_AW-1:0] padr,
	output logic [5:0]         shift,
	output logic [`LSQ_DW-1:0] res,
	output logic               datav,
	output logic               loadv,
	output lsq_state_e         state,
	output lsq_seq_t           seq_no
);

	// ============================================================
	// Control state
	// ============================================================

	// Only one command reaches this entry per cycle
	// A forward hit never lands on the entry being invalidated, since that one is the store
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
			load <= 1'b0;
			store <= 1'b0;
			agen <= 1'b0;
			datav <= 1'b0;
			loadv <= 1'b0;
			state <= IDLE;
		end else begin
			// Enqueue starts from a clean entry
			if (enq) begin
				valid <= 1'b1;
				load <= payload.adr.load;
				store <= payload.adr.store;
				agen <= 1'b0;
				datav <= 1'b0;
				loadv <= 1'b0;
				state <= IDLE;
			end
			// Translation is done and the physical address is now known
			if (set_adr) begin
				agen <= 1'b1;
			end
			// The access crossed a line, so it needs another translation
			if (inc_adr) begin
				agen <= 1'b0;
				state <= LINE_STEP;
			end
			if (set_res) begin
				datav <= 1'b1;
			end
			// On invalidate a load that was not committed keeps its data cached
			if (inv) begin
				valid <= 1'b0;
				load <= 1'b0;
				store <= 1'b0;
				agen <= 1'b0;
				datav <= 1'b0;
				loadv <= load && !commit;
				state <= IDLE;
			end
			if (fwd_hit) begin
				state <= FORWARDED;
			end
		end
	end

	// ============================================================
	// Payload fields
	// ============================================================

	always_ff @(posedge clk) begin
		if (enq) begin
			memsz <= lsq_memsz_e'(payload.adr.memsz);
			vadr <= payload.adr.adr;
			padr <= '0;
			shift <= '0;
			res <= '0;
			seq_no <= seq;
		end
		if (set_adr) begin
			padr <= payload.adr.adr;
			// The byte offset in the line is only taken on the first line
			if (state == IDLE) begin
				shift <= payload.adr.adr[5:0];
			end
		end
		// Step to the start of the next 64-byte line
		if (inc_adr) begin
			vadr <= {vadr[`LSQ_AW-1:6] + 1'b1, 6'd0};
		end
		// Flags in the result view are dropped
		if (set_res || inv) begin
			res <= payload.res.value;
		end
		if (fwd_hit) begin
			res <= fwd_data;
		end
	end

endmodule

`default_nettype wire

/* lsq_scan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module lsq_scan
	import lsq_entry_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    commit_scan,
	input  logic [`LSQ_ENTRIES-1:0] inv_sel,
	input  logic [`LSQ_ENTRIES-1:0] valid,
	input  logic [`LSQ_ENTRIES-1:0] load,
	input  logic [`LSQ_ENTRIES-1:0] store,
	input  logic [`LSQ_ENTRIES-1:0] agen,
	input  logic [`LSQ_ENTRIES-1:0] loadv,
	input  logic [`LSQ_ENTRIES-1:0] datav,
	input  lsq_memsz_e              memsz [`LSQ_ENTRIES],
	input  logic [`LSQ_AW-1:0]      vadr [`LSQ_ENTRIES],
	input  logic [`LSQ_AW-1:0]      padr [`LSQ_ENTRIES],
	input  logic [5:0]              shift [`LSQ_ENTRIES],
	input  logic [`LSQ_DW-1:0]      res [`LSQ_ENTRIES],
	input  lsq_seq_t                seq_no [`LSQ_ENTRIES],
	input  lsq_state_e              state [`LSQ_ENTRIES],
	input  logic [`LSQ_IW-1:0]      rd_idx,
	output logic [`LSQ_ENTRIES-1:0] fwd_hit,
	output logic [`LSQ_DW-1:0]      fwd_data,
	output logic                    fwd_valid,
	output logic [`LSQ_ENTRIES-1:0] fwd_mask,
	output logic                    rd_valid,
	output lsq_state_e              rd_state,
	output logic [`LSQ_AW-1:0]      rd_vadr,
	output logic [`LSQ_AW-1:0]      rd_padr,
	output logic [5:0]              rd_shift,
	output logic [`LSQ_DW-1:0]      rd_res,
	output logic                    rd_loadv,
	output logic                    rd_datav
);

	// Index of the entry being invalidated
	logic [`LSQ_IW-1:0] s_idx;
	// Set when some younger entry makes the forward unsafe
	logic               dis;
	// Younger than the store
	logic [`LSQ_ENTRIES-1:0] younger;

	// ============================================================
	// Store-to-load forwarding
	// ============================================================

	// Turn the one-hot invalidate select back into an index
	always_comb begin
		s_idx = '0;
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			if (inv_sel[i]) begin
				s_idx = s_idx | i[`LSQ_IW-1:0];
			end
		end
	end

	// All checks use entry state from before the commit edge
	always_comb begin
		dis = 1'b0;
		for (int j = 0; j < `LSQ_ENTRIES; j++) begin
			younger[j] = valid[j] && (seq_no[j] > seq_no[s_idx]);
			// A younger entry in the same 16-byte range, or with no address yet
			if (younger[j] && (!agen[j] || padr[j][`LSQ_AW-1:4] == padr[s_idx][`LSQ_AW-1:4])) begin
				// A later store owns the update of the loads after it
				if (store[j]) begin
					dis = 1'b1;
				end
				// A load of another size cannot take the store data as is
				if (load[j] && memsz[j] != memsz[s_idx]) begin
					dis = 1'b1;
				end
			end
		end
		for (int j = 0; j < `LSQ_ENTRIES; j++) begin
			fwd_hit[j] = commit_scan && store[s_idx] && !dis && younger[j] && load[j] &&
				(padr[j] == padr[s_idx]);
		end
	end

	assign fwd_data = res[s_idx];

	// Report the loads that were hit one cycle after the commit
	always_ff @(posedge clk) begin
		if (rst) begin
			fwd_valid <= 1'b0;
			fwd_mask <= '0;
		end else begin
			fwd_valid <= |fwd_hit;
			fwd_mask <= fwd_hit;
		end
	end

	// ============================================================
	// Read port
	// ============================================================

	assign rd_valid = valid[rd_idx];
	assign rd_state = state[rd_idx];
	assign rd_vadr = vadr[rd_idx];
	assign rd_padr = padr[rd_idx];
	assign rd_shift = shift[rd_idx];
	assign rd_res = res[rd_idx];
	assign rd_loadv = loadv[rd_idx];
	assign rd_datav = datav[rd_idx];

endmodule

`default_nettype wire

/* lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module lsq_top
	import lsq_cmd_pkg::*;
	import lsq_entry_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cmd_valid,
	input  lsq_op_e                 cmd_op,
	input  logic [`LSQ_IW-1:0]      cmd_idx,
	input  lsq_payload_u            cmd_payload,
	input  logic                    cmd_commit,
	input  logic [`LSQ_IW-1:0]      rd_idx,
	output logic                    fwd_valid,
	output logic [`LSQ_ENTRIES-1:0] fwd_mask,
	output logic                    rd_valid,
	output lsq_state_e              rd_state,
	output logic [`LSQ_AW-1:0]      rd_vadr,
	output logic [`LSQ_AW-1:0]      rd_padr,
	output logic [5:0]              rd_shift,
	output logic [`LSQ_DW-1:0]      rd_res,
	output logic                    rd_loadv,
	output logic                    rd_datav,
	output logic [`LSQ_IW-1:0]      tail
);

	// Per-entry command selects and broadcast fields
	logic [`LSQ_ENTRIES-1:0] enq_sel;
	logic [`LSQ_ENTRIES-1:0] adr_sel;
	logic [`LSQ_ENTRIES-1:0] inc_sel;
	logic [`LSQ_ENTRIES-1:0] res_sel;
	logic [`LSQ_ENTRIES-1:0] inv_sel;
	lsq_payload_u            bc_payload;
	logic                    bc_commit;
	lsq_seq_t                bc_seq;
	logic                    commit_scan;

	// Entry fields seen by the scanner
	logic [`LSQ_ENTRIES-1:0] valid;
	logic [`LSQ_ENTRIES-1:0] load;
	logic [`LSQ_ENTRIES-1:0] store;
	logic [`LSQ_ENTRIES-1:0] agen;
	logic [`LSQ_ENTRIES-1:0] loadv;
	logic [`LSQ_ENTRIES-1:0] datav;
	lsq_memsz_e              memsz [`LSQ_ENTRIES];
	logic [`LSQ_AW-1:0]      vadr [`LSQ_ENTRIES];
	logic [`LSQ_AW-1:0]      padr [`LSQ_ENTRIES];
	logic [5:0]              shift [`LSQ_ENTRIES];
	logic [`LSQ_DW-1:0]      res [`LSQ_ENTRIES];
	lsq_seq_t                seq_no [`LSQ_ENTRIES];
	lsq_state_e              state [`LSQ_ENTRIES];

	// Forward results back to the entries
	logic [`LSQ_ENTRIES-1:0] fwd_hit;
	logic [`LSQ_DW-1:0]      fwd_data;

	lsq_cmd_decode i_cmd_decode (
		.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
		.cmd_idx(cmd_idx), .cmd_payload(cmd_payload), .cmd_commit(cmd_commit),
		.enq_sel(enq_sel), .adr_sel(adr_sel), .inc_sel(inc_sel), .res_sel(res_sel),
		.inv_sel(inv_sel), .bc_payload(bc_payload), .bc_commit(bc_commit),
		.bc_seq(bc_seq), .commit_scan(commit_scan), .tail(tail)
	);

	// One entry per queue slot
	for (genvar g = 0; g < `LSQ_ENTRIES; g++) begin : g_entry
		lsq_entry i_entry (
			.clk(clk), .rst(rst), .enq(enq_sel[g]), .set_adr(adr_sel[g]),
			.inc_adr(inc_sel[g]), .set_res(res_sel[g]), .inv(inv_sel[g]),
			.payload(bc_payload), .commit(bc_commit), .seq(bc_seq),
			.fwd_hit(fwd_hit[g]), .fwd_data(fwd_data),
			.valid(valid[g]), .load(load[g]), .store(store[g]), .agen(agen[g]),
			.memsz(memsz[g]), .vadr(vadr[g]), .padr(padr[g]), .shift(shift[g]),
			.res(res[g]), .datav(datav[g]), .loadv(loadv[g]), .state(state[g]),
			.seq_no(seq_no[g])
		);
	end

	lsq_scan i_scan (
		.clk(clk), .rst(rst), .commit_scan(commit_scan), .inv_sel(inv_sel),
		.valid(valid), .load(load), .store(store), .agen(agen), .loadv(loadv),
		.datav(datav), .memsz(memsz), .vadr(vadr), .padr(padr), .shift(shift),
		.res(res), .seq_no(seq_no), .state(state), .rd_idx(rd_idx),
		.fwd_hit(fwd_hit), .fwd_data(fwd_data), .fwd_valid(fwd_valid),
		.fwd_mask(fwd_mask), .rd_valid(rd_valid), .rd_state(rd_state),
		.rd_vadr(rd_vadr), .rd_padr(rd_padr), .rd_shift(rd_shift), .rd_res(rd_res),
		.rd_loadv(rd_loadv), .rd_datav(rd_datav)
	);

endmodule

`default_nettype wire

/* tb_lsq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module tb_lsq
	import lsq_cmd_pkg::*;
	import lsq_entry_pkg::*;
();

	localparam int MAX_VEC = 64;
	localparam int RESET_CYCLES = 4;
	// Each vector takes two cycles, the rest is slack for the watchdog
	localparam int CYCLES_PER_VEC = 20;

	// ============================================================
	// DUT signals
	// ============================================================

	logic                    clk;
	logic                    rst;
	logic                    cmd_valid;
	lsq_op_e                 cmd_op;
	logic [`LSQ_IW-1:0]      cmd_idx;
	lsq_payload_u            cmd_payload;
	logic                    cmd_commit;
	logic [`LSQ_IW-1:0]      rd_idx;
	logic                    fwd_valid;
	logic [`LSQ_ENTRIES-1:0] fwd_mask;
	logic                    rd_valid;
	lsq_state_e              rd_state;
	logic [`LSQ_AW-1:0]      rd_vadr;
	logic [`LSQ_AW-1:0]      rd_padr;
	logic [5:0]              rd_shift;
	logic [`LSQ_DW-1:0]      rd_res;
	logic                    rd_loadv;
	logic                    rd_datav;
	logic [`LSQ_IW-1:0]      tail;

	// Vector table, one slot per line of the vectors file
	string                   vec_name [MAX_VEC];
	logic [2:0]              vec_op [MAX_VEC];
	logic [`LSQ_IW-1:0]      vec_idx [MAX_VEC];
	// Top nibble of the payload column is memory size, load and store
	logic [3:0]              vec_kind [MAX_VEC];
	logic [`LSQ_AW-1:0]      vec_word [MAX_VEC];
	logic                    vec_commit [MAX_VEC];
	logic [`LSQ_IW-1:0]      vec_rd [MAX_VEC];
	logic [7:0]              vec_chk [MAX_VEC];
	logic                    exp_valid [MAX_VEC];
	logic [1:0]              exp_state [MAX_VEC];
	logic [`LSQ_AW-1:0]      exp_vadr [MAX_VEC];
	logic [`LSQ_AW-1:0]      exp_padr [MAX_VEC];
	logic [5:0]              exp_shift [MAX_VEC];
	logic [`LSQ_DW-1:0]      exp_res [MAX_VEC];
	logic                    exp_loadv [MAX_VEC];
	logic                    exp_datav [MAX_VEC];
	logic [`LSQ_IW-1:0]      exp_tail [MAX_VEC];
	logic                    exp_fwdv [MAX_VEC];
	logic [`LSQ_ENTRIES-1:0] exp_mask [MAX_VEC];

	int   vec_count;
	int   load_errors;
	int   pass_cnt;
	int   fail_cnt;
	int   test_errs;
	logic vec_loaded;

	lsq_top i_lsq_top (
		.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
		.cmd_idx(cmd_idx), .cmd_payload(cmd_payload), .cmd_commit(cmd_commit),
		.rd_idx(rd_idx), .fwd_valid(fwd_valid), .fwd_mask(fwd_mask),
		.rd_valid(rd_valid), .rd_state(rd_state), .rd_vadr(rd_vadr),
		.rd_padr(rd_padr), .rd_shift(rd_shift), .rd_res(rd_res),
		.rd_loadv(rd_loadv), .rd_datav(rd_datav), .tail(tail)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ============================================================
	// Compare tasks, one per kind of result
	// ============================================================

	task automatic check_bit(input string name, input string field, input logic exp,
		input logic act);
		if (act !== exp) begin
			$display("ERR %s %s expected %0b actual %0b", name, field, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_state(input string name, input lsq_state_e exp, input lsq_state_e act);
		if (act !== exp) begin
			$display("ERR %s state expected %s(%0d) actual %s(%0d)", name, exp.name(), exp,
				act.name(), act);
			test_errs++;
		end
	endtask

	task automatic check_addr(input string name, input string field,
		input logic [`LSQ_AW-1:0] exp, input logic [`LSQ_AW-1:0] act);
		if (act !== exp) begin
			$display("ERR %s %s expected %h actual %h", name, field, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_data(input string name, input logic [`LSQ_DW-1:0] exp,
		input logic [`LSQ_DW-1:0] act);
		if (act !== exp) begin
			$display("ERR %s res expected %h actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_shift(input string name, input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp) begin
			$display("ERR %s shift expected %h actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_index(input string name, input logic [`LSQ_IW-1:0] exp,
		input logic [`LSQ_IW-1:0] act);
		if (act !== exp) begin
			$display("ERR %s tail expected %0d actual %0d", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_mask(input string name, input logic [`LSQ_ENTRIES-1:0] exp,
		input logic [`LSQ_ENTRIES-1:0] act);
		if (act !== exp) begin
			$display("ERR %s fwd_mask expected %h actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	// ============================================================
	// Vector file reader
	// ============================================================

	task automatic load_vectors();
		int          fd;
		int          cnt;
		string       line;
		string       t_name;
		logic [39:0] t_pay;
		logic [31:0] t_op;
		logic [31:0] t_idx;
		logic [31:0] t_commit;
		logic [31:0] t_rd;
		logic [31:0] t_chk;
		logic [31:0] t_valid;
		logic [31:0] t_state;
		logic [31:0] t_vadr;
		logic [31:0] t_padr;
		logic [31:0] t_shift;
		logic [31:0] t_res;
		logic [31:0] t_loadv;
		logic [31:0] t_datav;
		logic [31:0] t_tail;
		logic [31:0] t_fwdv;
		logic [31:0] t_mask;
		fd = $fopen("lsq_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vectors file lsq_vectors.txt");
			load_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			// Blank lines and comment lines carry no vector
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				t_name, t_op, t_idx, t_pay, t_commit, t_rd, t_chk, t_valid, t_state,
				t_vadr, t_padr, t_shift, t_res, t_loadv, t_datav, t_tail, t_fwdv, t_mask);
			if (cnt != 18) begin
				$display("Malformed line in the vectors file: %s", line);
				load_errors++;
				continue;
			end
			if (vec_count >= MAX_VEC) begin
				$display("Too many lines in the vectors file, the table holds %0d", MAX_VEC);
				load_errors++;
				break;
			end
			vec_name[vec_count] = t_name;
			vec_op[vec_count] = t_op[2:0];
			vec_idx[vec_count] = t_idx[`LSQ_IW-1:0];
			vec_kind[vec_count] = t_pay[39:36];
			vec_word[vec_count] = t_pay[`LSQ_AW-1:0];
			vec_commit[vec_count] = t_commit[0];
			vec_rd[vec_count] = t_rd[`LSQ_IW-1:0];
			vec_chk[vec_count] = t_chk[7:0];
			exp_valid[vec_count] = t_valid[0];
			exp_state[vec_count] = t_state[1:0];
			exp_vadr[vec_count] = t_vadr[`LSQ_AW-1:0];
			exp_padr[vec_count] = t_padr[`LSQ_AW-1:0];
			exp_shift[vec_count] = t_shift[5:0];
			exp_res[vec_count] = t_res[`LSQ_DW-1:0];
			exp_loadv[vec_count] = t_loadv[0];
			exp_datav[vec_count] = t_datav[0];
			exp_tail[vec_count] = t_tail[`LSQ_IW-1:0];
			exp_fwdv[vec_count] = t_fwdv[0];
			exp_mask[vec_count] = t_mask[`LSQ_ENTRIES-1:0];
			vec_count++;
		end
		$fclose(fd);
	endtask

	// ============================================================
	// One command and its checks
	// ============================================================

	task automatic run_vector(input int n);
		lsq_payload_u p;
		logic [31:0]  rnd;
		p = '0;
		rnd = $urandom();
		// Fill the view the opcode reads, with random spare bits and flags
		if (vec_op[n] == OP_ENQ || vec_op[n] == OP_SETADR) begin
			p.adr.memsz = vec_kind[n][3:2];
			p.adr.load = vec_kind[n][1];
			p.adr.store = vec_kind[n][0];
			p.adr.spare = rnd[$bits(p.adr.spare)-1:0];
			p.adr.adr = vec_word[n];
		end else if (vec_op[n] == OP_SETRES || vec_op[n] == OP_INV) begin
			p.res.flags = rnd[`LSQ_FW-1:0];
			p.res.value = vec_word[n];
		end
		test_errs = 0;
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_op = lsq_op_e'(vec_op[n]);
		cmd_idx = vec_idx[n];
		cmd_payload = p;
		cmd_commit = vec_commit[n];
		rd_idx = vec_rd[n];
		// Entry updates and the forward pulse are both visible in the next cycle
		@(negedge clk);
		if (vec_chk[n][0])
			check_bit(vec_name[n], "rd_valid", exp_valid[n], rd_valid);
		if (vec_chk[n][1])
			check_state(vec_name[n], lsq_state_e'(exp_state[n]), rd_state);
		if (vec_chk[n][2])
			check_addr(vec_name[n], "vadr", exp_vadr[n], rd_vadr);
		if (vec_chk[n][3])
			check_addr(vec_name[n], "padr", exp_padr[n], rd_padr);
		if (vec_chk[n][4])
			check_shift(vec_name[n], exp_shift[n], rd_shift);
		if (vec_chk[n][5])
			check_data(vec_name[n], exp_res[n], rd_res);
		if (vec_chk[n][6])
			check_bit(vec_name[n], "rd_loadv", exp_loadv[n], rd_loadv);
		if (vec_chk[n][7])
			check_bit(vec_name[n], "rd_datav", exp_datav[n], rd_datav);
		// Tail and forward outputs are checked on every vector
		check_index(vec_name[n], exp_tail[n], tail);
		check_bit(vec_name[n], "fwd_valid", exp_fwdv[n], fwd_valid);
		check_mask(vec_name[n], exp_mask[n], fwd_mask);
		cmd_valid = 1'b0;
		cmd_op = OP_NOP;
		cmd_commit = 1'b0;
		if (test_errs == 0) begin
			pass_cnt++;
			$display("PASS %s", vec_name[n]);
		end else begin
			fail_cnt++;
			$display("FAIL %s with %0d mismatches", vec_name[n], test_errs);
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		void'($urandom(69593));
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = OP_NOP;
		cmd_idx = '0;
		cmd_payload = '0;
		cmd_commit = 1'b0;
		rd_idx = '0;
		vec_count = 0;
		load_errors = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		test_errs = 0;
		vec_loaded = 1'b0;
		load_vectors();
		vec_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < vec_count; n++) begin
			run_vector(n);
		end
		$display("Summary: %0d vectors passed, %0d failed, %0d file errors",
			pass_cnt, fail_cnt, load_errors);
		if (fail_cnt == 0 && load_errors == 0 && vec_count > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog sized from the number of vectors, with one spare vector of slack
	initial begin
		wait (vec_loaded === 1'b1);
		repeat (RESET_CYCLES + CYCLES_PER_VEC * (vec_count + 1)) @(posedge clk);
		$display("The run timed out before all vectors finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* lsq_vectors.txt */
# name op idx payload commit rd_idx chk | valid state vadr padr shift res loadv datav tail fwdv mask
# payload top nibble is {memsz,load,store}, low 8 digits are address or result; chk bits 0..7 = valid state vadr padr shift res loadv datav
a_enq_ld   1 0 A000002238 0 0 C7 1 0 00002238 00000000 00 00000000 0 0 1 0 00
a_enq_st   1 0 1000003001 0 1 07 1 0 00003001 00000000 00 00000000 0 0 2 0 00
a_setadr   2 0 0080002238 0 0 1A 0 0 00000000 80002238 38 00000000 0 0 2 0 00
a_incadr   3 0 0000000000 0 0 06 0 1 00002240 00000000 00 00000000 0 0 2 0 00
a_setadr2  2 0 0080002240 0 0 18 0 0 00000000 80002240 38 00000000 0 0 2 0 00
a_setres   4 0 0012345678 0 0 A0 0 0 00000000 00000000 00 12345678 0 1 2 0 00
a_inv_ld   5 0 00CAFE0001 0 0 E3 0 0 00000000 00000000 00 CAFE0001 1 0 2 0 00
a_inv_st   5 1 0000000000 1 1 41 0 0 00000000 00000000 00 00000000 0 0 2 0 00
a_enq_ld2  1 0 2000004000 0 2 07 1 0 00004000 00000000 00 00000000 0 0 3 0 00
a_inv_ldc  5 2 0000000000 1 2 41 0 0 00000000 00000000 00 00000000 0 0 3 0 00
b_enq_st   1 0 9000005000 0 3 07 1 0 00005000 00000000 00 00000000 0 0 4 0 00
b_enq_ld   1 0 A000005000 0 4 07 1 0 00005000 00000000 00 00000000 0 0 5 0 00
b_adr_st   2 3 0000085010 0 3 18 0 0 00000000 00085010 10 00000000 0 0 5 0 00
b_adr_ld   2 4 0000085010 0 4 18 0 0 00000000 00085010 10 00000000 0 0 5 0 00
b_res_st   4 3 000BADF00D 0 3 A0 0 0 00000000 00000000 00 0BADF00D 0 1 5 0 00
b_commit   5 3 000BADF00D 1 4 23 1 3 00000000 00000000 00 0BADF00D 0 0 5 1 10
b_inv_ld   5 4 0000000000 1 4 41 0 0 00000000 00000000 00 00000000 0 0 5 0 00
c_enq_st1  1 0 9000006000 0 5 07 1 0 00006000 00000000 00 00000000 0 0 6 0 00
c_enq_st2  1 0 9000006008 0 6 07 1 0 00006008 00000000 00 00000000 0 0 7 0 00
c_enq_ld   1 0 A000006000 0 7 07 1 0 00006000 00000000 00 00000000 0 0 0 0 00
c_adr_st1  2 5 0000006000 0 5 18 0 0 00000000 00006000 00 00000000 0 0 0 0 00
c_adr_st2  2 6 0000006008 0 6 18 0 0 00000000 00006008 08 00000000 0 0 0 0 00
c_adr_ld   2 7 0000006000 0 7 18 0 0 00000000 00006000 00 00000000 0 0 0 0 00
c_res_st1  4 5 0011112222 0 5 A0 0 0 00000000 00000000 00 11112222 0 1 0 0 00
c_commit   5 5 0011112222 1 7 23 1 0 00000000 00000000 00 00000000 0 0 0 0 00
c_inv_st2  5 6 0000000000 1 6 41 0 0 00000000 00000000 00 00000000 0 0 0 0 00
c_inv_ld   5 7 0000000000 0 7 41 0 0 00000000 00000000 00 00000000 1 0 0 0 00
d_enq_st   1 0 9000007000 0 0 07 1 0 00007000 00000000 00 00000000 0 0 1 0 00
d_enq_st2  1 0 9000009000 0 1 07 1 0 00009000 00000000 00 00000000 0 0 2 0 00
d_enq_ld   1 0 A000007000 0 2 07 1 0 00007000 00000000 00 00000000 0 0 3 0 00
d_adr_st   2 0 0000007000 0 0 18 0 0 00000000 00007000 00 00000000 0 0 3 0 00
d_adr_ld   2 2 0000007000 0 2 18 0 0 00000000 00007000 00 00000000 0 0 3 0 00
d_commit   5 0 0033334444 1 2 23 1 0 00000000 00000000 00 00000000 0 0 3 0 00
d_inv_st2  5 1 0000000000 1 1 41 0 0 00000000 00000000 00 00000000 0 0 3 0 00
d_inv_ld   5 2 0000000000 1 2 41 0 0 00000000 00000000 00 00000000 0 0 3 0 00
e_enq_st   1 0 9000008000 0 3 07 1 0 00008000 00000000 00 00000000 0 0 4 0 00
e_enq_ld   1 0 2000008000 0 4 07 1 0 00008000 00000000 00 00000000 0 0 5 0 00
e_adr_st   2 3 0000008000 0 3 18 0 0 00000000 00008000 00 00000000 0 0 5 0 00
e_adr_ld   2 4 0000008000 0 4 18 0 0 00000000 00008000 00 00000000 0 0 5 0 00
e_commit   5 3 0055556666 1 4 23 1 0 00000000 00000000 00 00000000 0 0 5 0 00
e_inv_ld   5 4 0000000000 1 4 41 0 0 00000000 00000000 00 00000000 0 0 5 0 00

/* flist.f */
+incdir+.
lsq_cmd_pkg.sv
lsq_entry_pkg.sv
lsq_cmd_decode.sv
lsq_entry.sv
lsq_scan.sv
lsq_top.sv
tb_lsq.sv
